// File: design/eth_frame_pkg.sv
// ################################################
// Ethernet framing constants
// Preamble, delimiter, frame length limits and the
// byte-wise CRC-32 used for the frame check sequence
// ################################################

package eth_frame_pkg;

    // Preamble and start frame delimiter
    localparam logic [7:0] preamble_byte = 8'h55;
    localparam logic [7:0] sfd_byte      = 8'hD5;
    localparam int unsigned preamble_len = 7;

    // Minimum frame is 64 bytes with FCS, i.e. 60 bytes of payload
    localparam int unsigned min_frame_len = 64;
    localparam int unsigned fcs_len       = 4;

    // CRC-32, reflected form
    localparam logic [31:0] crc_poly    = 32'hEDB88320;
    localparam logic [31:0] crc_init    = 32'hFFFFFFFF;
    // Register value after data plus a good FCS has been shifted in
    localparam logic [31:0] crc_residue = 32'hDEBB20E3;

    // One byte of CRC-32, LSB of the byte goes first
    function automatic logic [31:0] crc32_step(
        input logic [31:0] crc,
        input logic [7:0]  data
    );
        logic [31:0] c;

        c = crc ^ {24'd0, data};
        for (int i = 0; i < 8; i++) begin
            if (c[0]) begin
                c = (c >> 1) ^ crc_poly;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

endpackage

// File: design/eth_mac_gmii.sv
// ################################################
// Gigabit Ethernet MAC, GMII side
// Receive decoder, transmit framer, speed detector
// ################################################

`timescale 1ns/1ps

module eth_mac_gmii (
    input  logic                    gtx_clk,
    input  logic                    gtx_rst,
    // Transmit stream
    input  mac_cfg_pkg::axis_byte_t tx_axis,
    input  logic                    tx_axis_tvalid,
    output logic                    tx_axis_tready,
    // Receive stream
    output mac_cfg_pkg::axis_byte_t rx_axis,
    output logic                    rx_axis_tvalid,
    // GMII
    input  logic                    gmii_rx_clk,
    input  mac_cfg_pkg::gmii_byte_t gmii_rx,
    output mac_cfg_pkg::gmii_byte_t gmii_tx,
    // Status and configuration
    output mac_cfg_pkg::rx_status_t rx_status,
    output mac_cfg_pkg::speed_t     speed,
    input  logic [7:0]              ifg_delay
);

    gmii_rx_decode rx_decode (
        .gtx_clk        (gtx_clk),
        .gtx_rst        (gtx_rst),
        .gmii_rx        (gmii_rx),
        .rx_axis        (rx_axis),
        .rx_axis_tvalid (rx_axis_tvalid),
        .rx_status      (rx_status)
    );

    gmii_tx_frame tx_frame (
        .gtx_clk        (gtx_clk),
        .gtx_rst        (gtx_rst),
        .tx_axis        (tx_axis),
        .tx_axis_tvalid (tx_axis_tvalid),
        .tx_axis_tready (tx_axis_tready),
        .ifg_delay      (ifg_delay),
        .gmii_tx        (gmii_tx)
    );

    // Measures only, the byte path stays at 1000M
    phy_speed_detect speed_detect (
        .gtx_clk     (gtx_clk),
        .gtx_rst     (gtx_rst),
        .gmii_rx_clk (gmii_rx_clk),
        .speed       (speed)
    );

endmodule

// File: design/gmii_rx_decode.sv
// ################################################
// GMII receive decoder
// Finds the start delimiter, strips preamble and FCS,
// checks the CRC and flags errored frames
// ################################################

`timescale 1ns/1ps

module gmii_rx_decode (
    input  logic                    gtx_clk,
    input  logic                    gtx_rst,
    input  mac_cfg_pkg::gmii_byte_t gmii_rx,
    output mac_cfg_pkg::axis_byte_t rx_axis,
    output logic                    rx_axis_tvalid,
    output mac_cfg_pkg::rx_status_t rx_status
);

    import eth_frame_pkg::*;
    import mac_cfg_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_data,
        st_drop
    } rx_state_t;

    rx_state_t   state;
    logic [31:0] crc;
    logic        er_seen;
    gmii_byte_t  dly_in;
    gmii_byte_t  dly_out;
    logic [7:0]  out_data;
    logic        out_valid;
    logic        frame_end;
    logic        fcs_bad;

    // Delay line input, en re-used as "byte belongs to the frame body"
    always_comb begin
        dly_in      = gmii_rx;
        dly_in.en   = (state == st_data) && gmii_rx.en;
    end

    // FCS sized delay so the last four bytes never reach the output
    shift_delay #(
        .T     (gmii_byte_t),
        .DEPTH (fcs_len)
    ) fcs_delay (
        .gtx_clk (gtx_clk),
        .gtx_rst (gtx_rst),
        .d       (dly_in),
        .q       (dly_out)
    );

    always_ff @(posedge gtx_clk) begin
        if (gtx_rst) begin
            state     <= st_idle;
            out_valid <= 1'b0;
        end else begin
            // Delayed byte is payload only while the frame still runs
            out_valid <= (state == st_data) && gmii_rx.en && dly_out.en;
            case (state)
                st_idle: begin
                    // Hunt for SFD, anything but preamble aborts
                    if (gmii_rx.en) begin
                        if (gmii_rx.data == sfd_byte) begin
                            state <= st_data;
                        end else if (gmii_rx.data != preamble_byte) begin
                            state <= st_drop;
                        end
                    end
                end
                st_data: begin
                    if (!gmii_rx.en) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    // Wait out a frame without a valid start
                    if (!gmii_rx.en) begin
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

    // Payload and CRC path
    always_ff @(posedge gtx_clk) begin
        out_data <= dly_out.data;
        if (state == st_idle) begin
            crc     <= crc_init;
            er_seen <= 1'b0;
        end else if ((state == st_data) && gmii_rx.en) begin
            // CRC covers the FCS too, good frames end on the residue
            crc     <= crc32_step(crc, gmii_rx.data);
            er_seen <= er_seen | gmii_rx.er;
        end
    end

    // First cycle with dv low marks the byte now on the output
    assign frame_end = (state == st_data) && !gmii_rx.en && out_valid;
    assign fcs_bad   = (crc != crc_residue);

    assign rx_axis.tdata  = out_data;
    assign rx_axis.tlast  = frame_end;
    assign rx_axis.tuser  = frame_end && (fcs_bad || er_seen);
    assign rx_axis_tvalid = out_valid;

    assign rx_status.bad_fcs   = frame_end && fcs_bad;
    assign rx_status.bad_frame = frame_end && er_seen;

    // No output strobe outside a frame
    a_no_valid_idle: assert property (
        @(posedge gtx_clk) disable iff (gtx_rst)
        rx_axis_tvalid |-> (state == st_data)
    );

endmodule

// File: design/gmii_tx_frame.sv
// ################################################
// GMII transmit framer
// Preamble, payload, zero padding, FCS and the
// inter-frame gap from an AXI byte stream
// ################################################

`timescale 1ns/1ps

module gmii_tx_frame (
    input  logic                    gtx_clk,
    input  logic                    gtx_rst,
    input  mac_cfg_pkg::axis_byte_t tx_axis,
    input  logic                    tx_axis_tvalid,
    output logic                    tx_axis_tready,
    input  logic [7:0]              ifg_delay,
    output mac_cfg_pkg::gmii_byte_t gmii_tx
);

    import eth_frame_pkg::*;
    import mac_cfg_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_preamble,
        st_data,
        st_pad,
        st_fcs,
        st_gap
    } tx_state_t;

    tx_state_t   state;
    tx_state_t   state_next;
    gmii_byte_t  tx_next;
    axis_byte_t  first_byte;
    logic [7:0]  cnt;
    logic [7:0]  gap_cnt;
    logic [7:0]  gap_load;
    logic [31:0] crc;
    logic [31:0] fcs_word;
    logic        err_flag;
    logic        tready_q;
    logic        accept;
    logic        more_pad;

    assign accept         = tx_axis_tvalid && tready_q;
    assign tx_axis_tready = tready_q;
    // cnt counts payload bytes already sent
    assign more_pad = (cnt < 8'(min_frame_len - fcs_len - 1));
    // Gap of at least one cycle
    assign gap_load = (ifg_delay == 8'd0) ? 8'd1 : ifg_delay;
    assign fcs_word = ~crc;

    // Next state and next GMII byte
    always_comb begin
        state_next = state;
        tx_next.data = 8'h00;
        tx_next.en   = 1'b1;
        tx_next.er   = 1'b0;
        case (state)
            st_idle: begin
                tx_next.en = accept;
                if (accept) begin
                    tx_next.data = preamble_byte;
                    state_next   = st_preamble;
                end
            end
            st_preamble: begin
                if (cnt < 8'(preamble_len)) begin
                    tx_next.data = preamble_byte;
                end else if (cnt == 8'(preamble_len)) begin
                    tx_next.data = sfd_byte;
                end else begin
                    // First byte was held since the start
                    tx_next.data = first_byte.tdata;
                    state_next   = first_byte.tlast ? st_pad : st_data;
                end
            end
            st_data: begin
                if (!tx_axis_tvalid) begin
                    // Underrun ends the frame with an error byte
                    tx_next.er = 1'b1;
                    state_next = st_gap;
                end else begin
                    tx_next.data = tx_axis.tdata;
                    if (tx_axis.tlast) begin
                        state_next = more_pad ? st_pad : st_fcs;
                    end
                end
            end
            st_pad: begin
                if (!more_pad) begin
                    state_next = st_fcs;
                end
            end
            st_fcs: begin
                // LSB first, er marks frames flagged by tuser
                tx_next.data = fcs_word[{cnt[1:0], 3'b000} +: 8];
                tx_next.er   = err_flag;
                if (cnt == 8'(fcs_len - 1)) begin
                    state_next = st_gap;
                end
            end
            default: begin
                tx_next.en = 1'b0;
                if (gap_cnt == 8'd0) begin
                    state_next = st_idle;
                end
            end
        endcase
    end

    // Control state
    always_ff @(posedge gtx_clk) begin
        if (gtx_rst) begin
            state    <= st_idle;
            tready_q <= 1'b0;
            gmii_tx  <= '0;
        end else begin
            state    <= state_next;
            // Ready only in states that take a byte
            tready_q <= (state_next == st_idle) || (state_next == st_data);
            gmii_tx  <= tx_next;
        end
    end

    // Counters, CRC and the held first byte
    always_ff @(posedge gtx_clk) begin
        case (state)
            st_idle: begin
                if (accept) begin
                    first_byte <= tx_axis;
                    cnt        <= 8'd1;
                end
            end
            st_preamble: begin
                cnt <= cnt + 8'd1;
                if (cnt == 8'(preamble_len + 1)) begin
                    cnt      <= 8'd1;
                    crc      <= crc32_step(crc_init, first_byte.tdata);
                    err_flag <= first_byte.tuser;
                end
            end
            st_data: begin
                if (tx_axis_tvalid) begin
                    crc <= crc32_step(crc, tx_axis.tdata);
                    if (tx_axis.tlast) begin
                        err_flag <= tx_axis.tuser;
                    end
                end
                if (more_pad) begin
                    cnt <= cnt + 8'd1;
                end
            end
            st_pad: begin
                crc <= crc32_step(crc, 8'h00);
                cnt <= cnt + 8'd1;
            end
            st_fcs: begin
                cnt <= cnt + 8'd1;
            end
            default: begin
                gap_cnt <= gap_cnt - 8'd1;
            end
        endcase
        // FCS index restarts from zero
        if ((state != st_fcs) && (state_next == st_fcs)) begin
            cnt <= 8'd0;
        end
        if ((state != st_gap) && (state_next == st_gap)) begin
            gap_cnt <= gap_load;
        end
    end

    // en unbroken from the first preamble byte to the last FCS byte
    a_en_frame: assert property (
        @(posedge gtx_clk) disable iff (gtx_rst)
        (state inside {st_preamble, st_data, st_pad, st_fcs}) |-> gmii_tx.en
    );

endmodule

// File: design/mac_cfg_pkg.sv
// ################################################
// MAC configuration types
// Stream and GMII byte structs, speed codes, receive
// status and speed detector sizing
// ################################################

package mac_cfg_pkg;

    // One GMII byte; en carries RX_DV on the receive side
    typedef struct packed {
        logic [7:0] data;
        logic       en;
        logic       er;
    } gmii_byte_t;

    // One byte of the AXI stream
    typedef struct packed {
        logic [7:0] tdata;
        logic       tlast;
        logic       tuser;
    } axis_byte_t;

    // Link speed, same codes as the usual MAC speed output
    typedef enum logic [1:0] {
        speed_10m   = 2'b00,
        speed_100m  = 2'b01,
        speed_1000m = 2'b10
    } speed_t;

    // Per-frame receive error pulses
    typedef struct packed {
        logic bad_frame;
        logic bad_fcs;
    } rx_status_t;

    // Speed detector sizing
    localparam int unsigned prescale_width   = 3;
    localparam int unsigned ref_count_width  = 7;
    localparam int unsigned edge_count_width = 2;
    localparam int unsigned sync_stages      = 3;

endpackage

// File: design/phy_speed_detect.sv
// ################################################
// PHY link speed detector
// Compares the receive clock rate with gtx_clk and
// reports 10M, 100M or 1000M
// ################################################

`timescale 1ns/1ps

module phy_speed_detect (
    input  logic                gtx_clk,
    input  logic                gtx_rst,
    input  logic                gmii_rx_clk,
    output mac_cfg_pkg::speed_t speed
);

    import mac_cfg_pkg::*;

    // Free running in the receive clock domain
    logic [prescale_width-1:0]   prescale = '0;
    logic                        toggle_sync;
    logic                        toggle_q;
    logic                        toggle_edge;
    logic [ref_count_width-1:0]  ref_count;
    logic [edge_count_width-1:0] edge_count;

    always_ff @(posedge gmii_rx_clk) begin
        prescale <= prescale + 1'b1;
    end

    // Prescaler MSB into gtx_clk
    shift_delay #(
        .T     (logic),
        .DEPTH (sync_stages)
    ) prescale_sync (
        .gtx_clk (gtx_clk),
        .gtx_rst (gtx_rst),
        .d       (prescale[prescale_width-1]),
        .q       (toggle_sync)
    );

    assign toggle_edge = toggle_sync ^ toggle_q;

    always_ff @(posedge gtx_clk) begin
        if (gtx_rst) begin
            toggle_q   <= 1'b0;
            ref_count  <= '0;
            edge_count <= '0;
            speed      <= speed_1000m;
        end else begin
            toggle_q  <= toggle_sync;
            ref_count <= ref_count + 1'b1;
            if (toggle_edge) begin
                edge_count <= edge_count + 1'b1;
            end
            if (&ref_count) begin
                // Window closed before enough edges, slow link
                ref_count  <= '0;
                edge_count <= '0;
                speed      <= speed_10m;
            end
            if (&edge_count) begin
                // Edges filled first, long window means 100M
                ref_count  <= '0;
                edge_count <= '0;
                if (|ref_count[ref_count_width-1 -: 2]) begin
                    speed <= speed_100m;
                end else begin
                    speed <= speed_1000m;
                end
            end
        end
    end

    // Speed moves only when a window closes
    a_speed_window: assert property (
        @(posedge gtx_clk) disable iff (gtx_rst)
        !$stable(speed) |-> (ref_count == '0) && (edge_count == '0)
    );

endmodule

// File: design/shift_delay.sv
// ################################################
// Fixed depth delay line
// Chain of DEPTH registers for any packed payload
// ################################################

`timescale 1ns/1ps

module shift_delay #(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = 4
) (
    input  logic gtx_clk,
    input  logic gtx_rst,
    input  T     d,
    output T     q
);

    T stage [DEPTH];

    always_ff @(posedge gtx_clk) begin
        if (gtx_rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage[i] <= '0;
            end
        end else begin
            stage[0] <= d;
            // Shift towards the last stage
            for (int i = 1; i < DEPTH; i++) begin
                stage[i] <= stage[i - 1];
            end
        end
    end

    // Oldest entry
    assign q = stage[DEPTH - 1];

endmodule

// File: list.f
design/eth_frame_pkg.sv
design/mac_cfg_pkg.sv
design/shift_delay.sv
design/gmii_rx_decode.sv
design/gmii_tx_frame.sv
design/phy_speed_detect.sv
design/eth_mac_gmii.sv
sim/tb_eth_mac_gmii.sv

// File: run.sh
#!/usr/bin/env bash
# Compile the MAC and its testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_eth_mac_gmii -f list.f -Mdir obj_dir \
    > build.log 2>&1 \
    && ./obj_dir/Vtb_eth_mac_gmii > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "Build or run error"; exit 1; }
cat sim.log
grep -qx "test passed" sim.log && echo "Simulation PASS" || { echo "Simulation FAIL"; exit 1; }

// File: sim/tb_eth_mac_gmii.sv
// ################################################
// Testbench for the GMII Ethernet MAC
// Directed transmit, receive and speed tests against
// a bit-serial reference CRC
// ################################################

`timescale 1ns/1ps

module tb_eth_mac_gmii;

    import eth_frame_pkg::*;
    import mac_cfg_pkg::*;

    typedef logic [7:0] byte_q_t[$];

    // Speed test takes 3 x 600 cycles, each frame test far less than 700
    localparam int speed_wait = 600;
    localparam int max_cycles = 3 * speed_wait + 6 * 700;

    logic       gtx_clk;
    logic       gtx_rst;
    axis_byte_t tx_axis;
    logic       tx_axis_tvalid;
    logic       tx_axis_tready;
    axis_byte_t rx_axis;
    logic       rx_axis_tvalid;
    logic       gmii_rx_clk;
    gmii_byte_t gmii_rx;
    gmii_byte_t gmii_tx;
    rx_status_t rx_status;
    speed_t     speed;
    logic [7:0] ifg_delay;

    realtime    rx_half = 4.0;
    int         seed;
    int         errors;
    int         checks;
    int         tests;
    int         test_errors;
    string      test_name;
    int         cycle_count;

    // Captured DUT responses
    byte_q_t    tx_data_q;
    logic       tx_er_q[$];
    axis_byte_t rx_byte_q[$];
    rx_status_t rx_stat_q[$];
    int         stray_status;

    eth_mac_gmii dut0 (
        .gtx_clk        (gtx_clk),
        .gtx_rst        (gtx_rst),
        .tx_axis        (tx_axis),
        .tx_axis_tvalid (tx_axis_tvalid),
        .tx_axis_tready (tx_axis_tready),
        .rx_axis        (rx_axis),
        .rx_axis_tvalid (rx_axis_tvalid),
        .gmii_rx_clk    (gmii_rx_clk),
        .gmii_rx        (gmii_rx),
        .gmii_tx        (gmii_tx),
        .rx_status      (rx_status),
        .speed          (speed),
        .ifg_delay      (ifg_delay)
    );

    initial begin
        gtx_clk = 1'b0;
        forever #10 gtx_clk = ~gtx_clk;
    end

    // PHY receive clock, half period changed by the speed test
    initial begin
        gmii_rx_clk = 1'b0;
        forever #(rx_half) gmii_rx_clk = ~gmii_rx_clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < max_cycles) begin
            @(posedge gtx_clk);
            cycle_count++;
        end
        $display("Timeout: run stopped after %0d clock cycles", cycle_count);
        $display("test failed");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("%s: %s", test_name, msg);
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = errors;
        tests++;
    endtask

    task automatic report_test();
        if (errors == test_errors) begin
            $display("%-16s ok", test_name);
        end else begin
            $display("%-16s %0d errors", test_name, errors - test_errors);
        end
    endtask

    // Bit-serial CRC-32, data LSB first, no final complement
    function automatic logic [31:0] ref_crc(input byte_q_t data);
        logic [31:0] c;
        logic        fb;

        c = 32'hFFFF_FFFF;
        foreach (data[i]) begin
            for (int b = 0; b < 8; b++) begin
                fb = c[0] ^ data[i][b];
                c  = {1'b0, c[31:1]};
                if (fb) begin
                    c = c ^ 32'hEDB8_8320;
                end
            end
        end
        return c;
    endfunction

    task automatic make_payload(input int len, output byte_q_t q);
        q = {};
        for (int i = 0; i < len; i++) begin
            q.push_back(8'($random(seed)));
        end
    endtask

    task automatic compare_bytes(input string name, input byte_q_t got, input byte_q_t exp);
        check_value({name, " length"}, 32'(got.size()), 32'(exp.size()));
        foreach (exp[i]) begin
            if (i < got.size()) begin
                check_value($sformatf("%s[%0d]", name, i), 32'(got[i]), 32'(exp[i]));
            end
        end
    endtask

    // One byte per accepting edge; ready seen in the low phase holds at the next edge
    task automatic send_tx_frame(input byte_q_t data, input logic err_last);
        foreach (data[i]) begin
            tx_axis.tdata  <= data[i];
            tx_axis.tlast  <= (i == data.size() - 1);
            tx_axis.tuser  <= err_last && (i == data.size() - 1);
            tx_axis_tvalid <= 1'b1;
            @(negedge gtx_clk);
            while (!tx_axis_tready) begin
                @(negedge gtx_clk);
            end
            @(posedge gtx_clk);
        end
        tx_axis_tvalid <= 1'b0;
        tx_axis        <= '0;
    endtask

    // Entered at a falling edge; idle counts low-en samples before the frame
    task automatic capture_tx(output int idle, output logic seen);
        idle      = 0;
        tx_data_q = {};
        tx_er_q   = {};
        while (!gmii_tx.en && idle < 300) begin
            idle++;
            @(negedge gtx_clk);
        end
        while (gmii_tx.en && tx_data_q.size() < 300) begin
            tx_data_q.push_back(gmii_tx.data);
            tx_er_q.push_back(gmii_tx.er);
            @(negedge gtx_clk);
        end
        seen = (tx_data_q.size() > 0);
    endtask

    task automatic put_rx(input logic [7:0] data, input logic er);
        gmii_rx <= '{data: data, en: 1'b1, er: er};
        @(posedge gtx_clk);
    endtask

    task automatic drive_rx_frame(input byte_q_t data, input logic [31:0] fcs,
                                  input int er_at);
        for (int i = 0; i < int'(preamble_len); i++) begin
            put_rx(preamble_byte, 1'b0);
        end
        put_rx(sfd_byte, 1'b0);
        foreach (data[i]) begin
            put_rx(data[i], (i == er_at));
        end
        // FCS goes out least significant byte first
        for (int i = 0; i < int'(fcs_len); i++) begin
            put_rx(fcs[8*i +: 8], 1'b0);
        end
        gmii_rx <= '0;
    endtask

    task automatic capture_rx(input int max_wait, output logic got_last);
        got_last     = 1'b0;
        rx_byte_q    = {};
        rx_stat_q    = {};
        stray_status = 0;
        for (int c = 0; c < max_wait && !got_last; c++) begin
            @(negedge gtx_clk);
            if (rx_axis_tvalid) begin
                rx_byte_q.push_back(rx_axis);
                rx_stat_q.push_back(rx_status);
                got_last = rx_axis.tlast;
            end else if (rx_status != '0) begin
                stray_status++;
            end
        end
    endtask

    task automatic test_reset_values();
        start_test("reset_values");
        check_value("tx_axis_tready", 32'(tx_axis_tready), 32'h0);
        check_value("gmii_tx.en", 32'(gmii_tx.en), 32'h0);
        check_value("gmii_tx.er", 32'(gmii_tx.er), 32'h0);
        check_value("rx_axis_tvalid", 32'(rx_axis_tvalid), 32'h0);
        check_value("rx_status", 32'(rx_status), 32'h0);
        check_value("speed", 32'(speed), 32'(speed_1000m));
        report_test();
    endtask

    task automatic test_tx_short();
        byte_q_t     payload;
        byte_q_t     exp;
        logic [31:0] fcs;
        int          idle;
        logic        seen;

        start_test("tx_short_frame");
        make_payload(20, payload);
        @(posedge gtx_clk);
        fork
            send_tx_frame(payload, 1'b0);
            begin
                @(negedge gtx_clk);
                capture_tx(idle, seen);
            end
        join
        if (!seen) begin
            report_error("no frame appeared on gmii_tx");
        end
        // Zero padding up to 60 bytes, FCS over payload and padding
        while (payload.size() < int'(min_frame_len - fcs_len)) begin
            payload.push_back(8'h00);
        end
        fcs = ~ref_crc(payload);
        exp = {};
        for (int i = 0; i < int'(preamble_len); i++) begin
            exp.push_back(preamble_byte);
        end
        exp.push_back(sfd_byte);
        foreach (payload[i]) begin
            exp.push_back(payload[i]);
        end
        for (int i = 0; i < int'(fcs_len); i++) begin
            exp.push_back(fcs[8*i +: 8]);
        end
        compare_bytes("gmii_tx.data", tx_data_q, exp);
        foreach (tx_er_q[i]) begin
            check_value("gmii_tx.er", 32'(tx_er_q[i]), 32'h0);
        end
        report_test();
    endtask

    task automatic test_tx_gap();
        byte_q_t first;
        byte_q_t second;
        logic    er_first[$];
        int      idle;
        int      gap;
        logic    seen_a;
        logic    seen_b;

        start_test("tx_error_gap");
        make_payload(70, first);
        make_payload(70, second);
        @(posedge gtx_clk);
        fork
            begin
                send_tx_frame(first, 1'b1);
                send_tx_frame(second, 1'b0);
            end
            begin
                @(negedge gtx_clk);
                capture_tx(idle, seen_a);
                er_first = tx_er_q;
                // Starts on the first idle sample after frame A
                capture_tx(gap, seen_b);
            end
        join
        if (!seen_a || !seen_b) begin
            report_error("expected two frames on gmii_tx");
        end
        // 8 preamble bytes, 70 data bytes, FCS at 78 to 81
        check_value("frame a length", 32'(er_first.size()), 32'd82);
        check_value("frame b length", 32'(tx_er_q.size()), 32'd82);
        foreach (er_first[i]) begin
            check_value($sformatf("gmii_tx.er a[%0d]", i), 32'(er_first[i]), 32'(i >= 78));
        end
        foreach (tx_er_q[i]) begin
            check_value($sformatf("gmii_tx.er b[%0d]", i), 32'(tx_er_q[i]), 32'h0);
        end
        if (gap < int'(ifg_delay)) begin
            report_error($sformatf("en was low for only %0d cycles between frames, %0d needed",
                                   gap, ifg_delay));
        end
        report_test();
    endtask

    task automatic test_rx_frame(input string name, input logic flip_fcs, input int er_at);
        byte_q_t     payload;
        byte_q_t     got;
        logic [31:0] fcs;
        logic        got_last;
        logic        last;
        logic        rx_err;

        start_test(name);
        make_payload(64, payload);
        fcs = ~ref_crc(payload);
        if (flip_fcs) begin
            fcs[9] = ~fcs[9];
        end
        rx_err = (er_at >= 0);
        repeat (4) @(posedge gtx_clk);
        fork
            drive_rx_frame(payload, fcs, er_at);
            capture_rx(120, got_last);
        join
        if (!got_last) begin
            report_error("no tlast strobe seen on rx_axis");
        end
        got = {};
        foreach (rx_byte_q[i]) begin
            got.push_back(rx_byte_q[i].tdata);
        end
        compare_bytes("rx_axis.tdata", got, payload);
        foreach (rx_byte_q[i]) begin
            last = (i == 63);
            check_value("rx_axis.tlast", 32'(rx_byte_q[i].tlast), 32'(last));
            check_value("rx_axis.tuser", 32'(rx_byte_q[i].tuser),
                        32'(last && (flip_fcs || rx_err)));
            check_value("rx_status.bad_fcs", 32'(rx_stat_q[i].bad_fcs), 32'(last && flip_fcs));
            check_value("rx_status.bad_frame", 32'(rx_stat_q[i].bad_frame), 32'(last && rx_err));
        end
        check_value("stray status pulses", 32'(stray_status), 32'h0);
        report_test();
    endtask

    // Edge every 4, 40 or 400 cycles against a 128 cycle window
    task automatic test_speed();
        realtime half_ns [3];
        speed_t  exp_speed [3];

        half_ns   = '{10.0, 100.0, 1000.0};
        exp_speed = '{speed_1000m, speed_100m, speed_10m};
        start_test("speed_detect");
        for (int k = 0; k < 3; k++) begin
            rx_half = half_ns[k];
            repeat (speed_wait) @(posedge gtx_clk);
            @(negedge gtx_clk);
            check_value("speed", 32'(speed), 32'(exp_speed[k]));
        end
        report_test();
    endtask

    initial begin
        seed   = 32'hb86b;
        errors = 0;
        checks = 0;
        tests  = 0;
        gtx_rst        <= 1'b1;
        tx_axis        <= '0;
        tx_axis_tvalid <= 1'b0;
        gmii_rx        <= '0;
        ifg_delay      <= 8'd12;
        @(posedge gtx_clk);
        @(negedge gtx_clk);
        test_reset_values();
        @(posedge gtx_clk);
        gtx_rst <= 1'b0;

        test_tx_short();
        test_tx_gap();
        test_rx_frame("rx_good_frame", 1'b0, -1);
        test_rx_frame("rx_bad_fcs", 1'b1, -1);
        test_rx_frame("rx_error", 1'b0, 30);
        test_speed();

        $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
